//--- files.f
+incdir+source
+incdir+tb
source/standby_pkg.sv
source/tti_rx_word_to_byte.sv
source/tti_tx_byte_to_word.sv
source/controller_standby_tti.sv
tb/tb_controller_standby_tti.sv

//--- run.sh
#!/usr/bin/env bash
set -e
set -o pipefail

cd "$(dirname "$0")"

verilator --binary --timing --timescale 1ns/1ps \
  --top-module tb_controller_standby_tti -f files.f

output="$(./obj_dir/Vtb_controller_standby_tti)"
echo "$output"

if echo "$output" | grep -qx "test passed"; then
  exit 0
else
  exit 1
fi

//--- tb/standby_model.svh
// Standby TTI reference model

`ifndef STANDBY_MODEL_SVH
`define STANDBY_MODEL_SVH

  logic [31:0] lcg_state = 32'hc059_3dcd;
  int unsigned err_count = 0;
  int unsigned check_count = 0;

  // LCG step with halves swapped since the low bits repeat quickly
  function automatic logic [31:0] next_rand();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return {lcg_state[15:0], lcg_state[31:16]};
  endfunction

  // Byte k of a word with byte 0 as the least significant
  function automatic logic [`TTI_BYTE_W-1:0] byte_of_word(
    input logic [`TTI_WORD_W-1:0] word,
    input int unsigned            k
  );
    logic [`TTI_WORD_W-1:0] shifted;
    shifted = word >> (k * `TTI_BYTE_W);
    return shifted[`TTI_BYTE_W-1:0];
  endfunction

  // First byte lands in the least significant position
  function automatic logic [`TTI_WORD_W-1:0] word_from_bytes(
    input logic [`TTI_BYTE_W-1:0] b0,
    input logic [`TTI_BYTE_W-1:0] b1,
    input logic [`TTI_BYTE_W-1:0] b2,
    input logic [`TTI_BYTE_W-1:0] b3
  );
    return {b3, b2, b1, b0};
  endfunction

  // Sticky flag where a status read clear has priority
  function automatic logic next_err_flag(
    input logic cur,
    input logic parity,
    input logic status_done
  );
    if (status_done) begin
      return 1'b0;
    end
    if (parity) begin
      return 1'b1;
    end
    return cur;
  endfunction

  function automatic logic cfg_selects_i3c(input standby_pkg::mode_cfg_t cfg);
    return cfg.i3c_active_en | cfg.i3c_standby_en;
  endfunction

  task automatic check_value(
    input string       name,
    input logic [31:0] got,
    input logic [31:0] exp
  );
    check_count++;
    if (got !== exp) begin
      err_count++;
      $display("ERROR at %0d ns: %s is 0x%0h, expected 0x%0h", $time, name, got, exp);
    end
  endtask

  task automatic note_failure(input string what);
    err_count++;
    $display("At %0d ns: %s", $time, what);
  endtask

`endif

//--- tb/tb_controller_standby_tti.sv
// Standby TTI testbench

`default_nettype none

`include "standby_defs.svh"

module tb_controller_standby_tti;
  timeunit 1ns;
  timeprecision 1ps;

  localparam int unsigned cycle_limit = 20000;

  logic                    clk;
  logic                    rst_n;
  standby_pkg::mode_cfg_t  mode_cfg;
  logic                    i2c_rx_word_valid;
  logic                    i2c_rx_word_ready;
  logic [`TTI_WORD_W-1:0]  i2c_rx_word_data;
  logic                    i2c_tx_word_valid;
  logic                    i2c_tx_word_ready;
  logic [`TTI_WORD_W-1:0]  i2c_tx_word_data;
  standby_pkg::bus_event_t i2c_bus_event;
  standby_pkg::bus_addr_t  i2c_bus_addr;
  logic                    i3c_rx_byte_valid;
  logic                    i3c_rx_byte_ready;
  logic [`TTI_BYTE_W-1:0]  i3c_rx_byte_data;
  logic                    i3c_rx_flush;
  logic                    i3c_tx_byte_valid;
  logic                    i3c_tx_byte_ready;
  logic [`TTI_BYTE_W-1:0]  i3c_tx_byte_data;
  logic                    i3c_tx_flush;
  standby_pkg::bus_event_t i3c_bus_event;
  standby_pkg::bus_addr_t  i3c_bus_addr;
  logic                    parity_err;
  logic                    get_status_done;
  logic                    rx_queue_wvalid;
  logic                    rx_queue_wready;
  logic [`TTI_BYTE_W-1:0]  rx_queue_wdata;
  logic                    rx_queue_flush;
  logic                    tx_queue_rvalid;
  logic                    tx_queue_rready;
  logic [`TTI_BYTE_W-1:0]  tx_queue_rdata;
  logic                    tx_queue_flush;
  standby_pkg::bus_event_t bus_event;
  standby_pkg::bus_addr_t  bus_addr;
  logic                    err;

  // Expected traffic and transfer counts seen at the inputs
  logic [`TTI_BYTE_W-1:0]     rx_exp[$];
  logic [`TTI_WORD_W-1:0]     tx_word_exp[$];
  logic [`TTI_BYTE_W-1:0]     tx_byte_exp[$];
  logic [`TTI_BYTE_W-1:0]     tx_part[`TTI_BYTES_PER_WORD];
  logic [`TTI_BYTE_IDX_W-1:0] tx_part_cnt = '0;
  int unsigned                rx_word_in = 0;
  int unsigned                rx_byte_in = 0;
  int unsigned                tx_byte_in = 0;
  logic                       exp_err = 1'b0;
  logic                       timed_out = 1'b0;

  `include "standby_model.svh"

  controller_standby_tti u_dut (
    .clk_i               (clk),
    .rst_ni              (rst_n),
    .mode_cfg_i          (mode_cfg),
    .i2c_rx_word_valid_i (i2c_rx_word_valid),
    .i2c_rx_word_ready_o (i2c_rx_word_ready),
    .i2c_rx_word_data_i  (i2c_rx_word_data),
    .i2c_tx_word_valid_o (i2c_tx_word_valid),
    .i2c_tx_word_ready_i (i2c_tx_word_ready),
    .i2c_tx_word_data_o  (i2c_tx_word_data),
    .i2c_bus_event_i     (i2c_bus_event),
    .i2c_bus_addr_i      (i2c_bus_addr),
    .i3c_rx_byte_valid_i (i3c_rx_byte_valid),
    .i3c_rx_byte_ready_o (i3c_rx_byte_ready),
    .i3c_rx_byte_data_i  (i3c_rx_byte_data),
    .i3c_rx_flush_i      (i3c_rx_flush),
    .i3c_tx_byte_valid_o (i3c_tx_byte_valid),
    .i3c_tx_byte_ready_i (i3c_tx_byte_ready),
    .i3c_tx_byte_data_o  (i3c_tx_byte_data),
    .i3c_tx_flush_i      (i3c_tx_flush),
    .i3c_bus_event_i     (i3c_bus_event),
    .i3c_bus_addr_i      (i3c_bus_addr),
    .parity_err_i        (parity_err),
    .get_status_done_i   (get_status_done),
    .rx_queue_wvalid_o   (rx_queue_wvalid),
    .rx_queue_wready_i   (rx_queue_wready),
    .rx_queue_wdata_o    (rx_queue_wdata),
    .rx_queue_flush_o    (rx_queue_flush),
    .tx_queue_rvalid_i   (tx_queue_rvalid),
    .tx_queue_rready_o   (tx_queue_rready),
    .tx_queue_rdata_i    (tx_queue_rdata),
    .tx_queue_flush_o    (tx_queue_flush),
    .bus_event_o         (bus_event),
    .bus_addr_o          (bus_addr),
    .err_o               (err)
  );

  initial clk = 1'b0;
  always #5 clk = ~clk;

  function automatic standby_pkg::mode_cfg_t pick_mode_cfg(input logic use_i3c);
    standby_pkg::mode_cfg_t cfg;
    logic [31:0]            r;
    r = next_rand();
    cfg = r[3:0];
    if (!use_i3c) begin
      cfg.i3c_active_en  = 1'b0;
      cfg.i3c_standby_en = 1'b0;
    end else if (!cfg.i3c_active_en && !cfg.i3c_standby_en) begin
      cfg.i3c_standby_en = 1'b1;
    end
    return cfg;
  endfunction

  task automatic init_inputs();
    mode_cfg = '0;
    i2c_rx_word_valid = 1'b0;
    i2c_rx_word_data = '0;
    i2c_tx_word_ready = 1'b0;
    i2c_bus_event = '0;
    i2c_bus_addr = '0;
    i3c_rx_byte_valid = 1'b0;
    i3c_rx_byte_data = '0;
    i3c_rx_flush = 1'b0;
    i3c_tx_byte_ready = 1'b0;
    i3c_tx_flush = 1'b0;
    i3c_bus_event = '0;
    i3c_bus_addr = '0;
    parity_err = 1'b0;
    get_status_done = 1'b0;
    rx_queue_wready = 1'b0;
    tx_queue_rvalid = 1'b0;
    tx_queue_rdata = '0;
  endtask

  // Random traffic in one mode until n items pass each way and all queues drain
  task automatic run_traffic(input logic use_i3c, input int unsigned n);
    int unsigned rx_base;
    int unsigned tx_base;
    int unsigned rx_seen;
    int unsigned tx_seen;
    int unsigned rx_now;
    int unsigned tx_target;
    int unsigned cycles;
    logic        finished;
    logic [31:0] r;
    logic [31:0] d;
    tx_target = use_i3c ? n : n * `TTI_BYTES_PER_WORD;
    rx_base = use_i3c ? rx_byte_in : rx_word_in;
    tx_base = tx_byte_in;
    rx_seen = rx_base;
    tx_seen = tx_base;
    cycles = 0;
    finished = 1'b0;
    mode_cfg = pick_mode_cfg(use_i3c);
    while (!finished && !timed_out) begin
      rx_now = use_i3c ? rx_byte_in : rx_word_in;
      if (rx_now - rx_base == n && tx_byte_in - tx_base == tx_target &&
          rx_exp.size() == 0 && tx_word_exp.size() == 0 && tx_byte_exp.size() == 0) begin
        finished = 1'b1;
      end else begin
        r = next_rand();
        d = next_rand();
        // A raised valid keeps its data until the transfer
        if (use_i3c && (!i3c_rx_byte_valid || rx_now != rx_seen)) begin
          i3c_rx_byte_valid = (rx_now - rx_base < n) && (r[1:0] != 2'b00);
          i3c_rx_byte_data = d[7:0];
        end
        if (!use_i3c && (!i2c_rx_word_valid || rx_now != rx_seen)) begin
          i2c_rx_word_valid = (rx_now - rx_base < n) && (r[1:0] != 2'b00);
          i2c_rx_word_data = next_rand();
        end
        if (!tx_queue_rvalid || tx_byte_in != tx_seen) begin
          tx_queue_rvalid = (tx_byte_in - tx_base < tx_target) && (r[3:2] != 2'b00);
          tx_queue_rdata = d[15:8];
        end
        rx_seen = rx_now;
        tx_seen = tx_byte_in;
        rx_queue_wready = (r[5:4] != 2'b00);
        i2c_tx_word_ready = r[6];
        i3c_tx_byte_ready = (r[8:7] != 2'b00);
        i3c_rx_flush = r[9];
        i3c_tx_flush = r[10];
        parity_err = (r[13:11] == 3'd0);
        get_status_done = (r[16:14] == 3'd0);
        d = next_rand();
        i2c_bus_event = d[2:0];
        i2c_bus_addr = d[11:3];
        i3c_bus_event = d[14:12];
        i3c_bus_addr = d[23:15];
        @(negedge clk);
        cycles++;
        if (cycles > cycle_limit) begin
          timed_out = 1'b1;
          $display("Timeout: traffic did not drain within %0d cycles", cycle_limit);
        end
      end
    end
    i2c_rx_word_valid = 1'b0;
    i3c_rx_byte_valid = 1'b0;
    tx_queue_rvalid = 1'b0;
  endtask

  // Records input transfers, then compares outputs against the expected items
  always @(posedge clk) begin : compare
    logic                   i3c;
    logic [`TTI_WORD_W-1:0] exp_val;
    if (!rst_n) begin
      exp_err = 1'b0;
      check_value("rx_queue_wvalid_o", 32'(rx_queue_wvalid), 32'd0);
      check_value("i2c_tx_word_valid_o", 32'(i2c_tx_word_valid), 32'd0);
      check_value("i3c_tx_byte_valid_o", 32'(i3c_tx_byte_valid), 32'd0);
      check_value("err_o", 32'(err), 32'd0);
    end else begin
      i3c = cfg_selects_i3c(mode_cfg);
      if (i2c_rx_word_valid && i2c_rx_word_ready) begin
        rx_word_in++;
        for (int unsigned k = 0; k < `TTI_BYTES_PER_WORD; k++) begin
          rx_exp.push_back(byte_of_word(i2c_rx_word_data, k));
        end
      end
      if (i3c_rx_byte_valid && i3c_rx_byte_ready) begin
        rx_byte_in++;
        rx_exp.push_back(i3c_rx_byte_data);
      end
      if (tx_queue_rvalid && tx_queue_rready) begin
        tx_byte_in++;
        if (i3c) begin
          tx_byte_exp.push_back(tx_queue_rdata);
        end else begin
          tx_part[tx_part_cnt] = tx_queue_rdata;
          if (tx_part_cnt == {`TTI_BYTE_IDX_W{1'b1}}) begin
            tx_word_exp.push_back(word_from_bytes(tx_part[0], tx_part[1], tx_part[2],
                                                  tx_part[3]));
          end
          tx_part_cnt = tx_part_cnt + 1'b1;
        end
      end

      if (rx_queue_wvalid && rx_queue_wready) begin
        if (rx_exp.size() == 0) begin
          note_failure("RX queue was written with no byte expected");
        end else begin
          exp_val = 32'(rx_exp.pop_front());
          check_value("rx_queue_wdata_o", 32'(rx_queue_wdata), exp_val);
        end
      end
      if (i2c_tx_word_valid && i2c_tx_word_ready) begin
        if (tx_word_exp.size() == 0) begin
          note_failure("I2C engine got a TX word with no word expected");
        end else begin
          exp_val = tx_word_exp.pop_front();
          check_value("i2c_tx_word_data_o", i2c_tx_word_data, exp_val);
        end
      end
      if (i3c_tx_byte_valid && i3c_tx_byte_ready) begin
        if (tx_byte_exp.size() == 0) begin
          note_failure("I3C engine got a TX byte with no byte expected");
        end else begin
          exp_val = 32'(tx_byte_exp.pop_front());
          check_value("i3c_tx_byte_data_o", 32'(i3c_tx_byte_data), exp_val);
        end
      end

      // Mode routing of handshakes, flushes and bus information
      check_value("rx_queue_flush_o", 32'(rx_queue_flush), 32'(i3c & i3c_rx_flush));
      check_value("tx_queue_flush_o", 32'(tx_queue_flush), 32'(i3c & i3c_tx_flush));
      check_value("i3c_rx_byte_ready_o", 32'(i3c_rx_byte_ready), 32'(i3c & rx_queue_wready));
      check_value("i3c_tx_byte_valid_o", 32'(i3c_tx_byte_valid), 32'(i3c & tx_queue_rvalid));
      if (i3c) begin
        check_value("i2c_tx_word_valid_o", 32'(i2c_tx_word_valid), 32'd0);
        check_value("i2c_rx_word_ready_o", 32'(i2c_rx_word_ready), 32'd0);
        check_value("rx_queue_wvalid_o", 32'(rx_queue_wvalid), 32'(i3c_rx_byte_valid));
        check_value("tx_queue_rready_o", 32'(tx_queue_rready), 32'(i3c_tx_byte_ready));
      end
      check_value("bus_event_o", 32'(bus_event), 32'(i3c ? i3c_bus_event : i2c_bus_event));
      check_value("bus_addr_o", 32'(bus_addr), 32'(i3c ? i3c_bus_addr : i2c_bus_addr));

      check_value("err_o", 32'(err), 32'(exp_err));
      exp_err = next_err_flag(exp_err, parity_err, get_status_done);
    end
  end

  initial begin
    init_inputs();
    rst_n = 1'b0;
    repeat (4) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;

    run_traffic(1'b0, 40);
    if (!timed_out) run_traffic(1'b1, 100);
    if (!timed_out) run_traffic(1'b0, 25);
    if (!timed_out) run_traffic(1'b1, 60);
    @(negedge clk);

    $display("Summary: %0d checks, %0d errors, %0d timeouts", check_count, err_count,
             timed_out ? 1 : 0);
    if (err_count == 0 && !timed_out) begin
      $display("test passed");
    end else begin
      $display("test failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- source/controller_standby_tti.sv
// Standby controller TTI layer

`default_nettype none

`include "standby_defs.svh"

module controller_standby_tti (
  input  logic                    clk_i,
  input  logic                    rst_ni,

  input  standby_pkg::mode_cfg_t  mode_cfg_i,

  // I2C engine, RX words
  input  logic                    i2c_rx_word_valid_i,
  output logic                    i2c_rx_word_ready_o,
  input  logic [`TTI_WORD_W-1:0]  i2c_rx_word_data_i,

  // I2C engine, TX words
  output logic                    i2c_tx_word_valid_o,
  input  logic                    i2c_tx_word_ready_i,
  output logic [`TTI_WORD_W-1:0]  i2c_tx_word_data_o,

  input  standby_pkg::bus_event_t i2c_bus_event_i,
  input  standby_pkg::bus_addr_t  i2c_bus_addr_i,

  // I3C engine, RX bytes
  input  logic                    i3c_rx_byte_valid_i,
  output logic                    i3c_rx_byte_ready_o,
  input  logic [`TTI_BYTE_W-1:0]  i3c_rx_byte_data_i,
  input  logic                    i3c_rx_flush_i,

  // I3C engine, TX bytes
  output logic                    i3c_tx_byte_valid_o,
  input  logic                    i3c_tx_byte_ready_i,
  output logic [`TTI_BYTE_W-1:0]  i3c_tx_byte_data_o,
  input  logic                    i3c_tx_flush_i,

  input  standby_pkg::bus_event_t i3c_bus_event_i,
  input  standby_pkg::bus_addr_t  i3c_bus_addr_i,
  input  logic                    parity_err_i,
  input  logic                    get_status_done_i,

  // RX data queue
  output logic                    rx_queue_wvalid_o,
  input  logic                    rx_queue_wready_i,
  output logic [`TTI_BYTE_W-1:0]  rx_queue_wdata_o,
  output logic                    rx_queue_flush_o,

  // TX data queue
  input  logic                    tx_queue_rvalid_i,
  output logic                    tx_queue_rready_o,
  input  logic [`TTI_BYTE_W-1:0]  tx_queue_rdata_i,
  output logic                    tx_queue_flush_o,

  output standby_pkg::bus_event_t bus_event_o,
  output standby_pkg::bus_addr_t  bus_addr_o,
  output logic                    err_o
);

  standby_pkg::tti_mode_e mode;
  logic                   i3c_sel;
  logic                   i2c_sel;

  // Either I3C enable selects the I3C engine
  assign mode = (mode_cfg_i.i3c_active_en | mode_cfg_i.i3c_standby_en) ?
                standby_pkg::MODE_I3C : standby_pkg::MODE_I2C;
  assign i3c_sel = (mode == standby_pkg::MODE_I3C);
  assign i2c_sel = (mode == standby_pkg::MODE_I2C);

  logic                   rx_conv_word_valid;
  logic                   rx_conv_word_ready;
  logic                   rx_conv_byte_valid;
  logic                   rx_conv_byte_ready;
  logic [`TTI_BYTE_W-1:0] rx_conv_byte_data;

  logic                   tx_conv_byte_valid;
  logic                   tx_conv_byte_ready;
  logic                   tx_conv_word_valid;
  logic                   tx_conv_word_ready;
  logic [`TTI_WORD_W-1:0] tx_conv_word_data;

  // Converters only see traffic in I2C mode
  assign rx_conv_word_valid = i2c_rx_word_valid_i & i2c_sel;
  assign rx_conv_byte_ready = rx_queue_wready_i & i2c_sel;
  assign tx_conv_byte_valid = tx_queue_rvalid_i & i2c_sel;
  assign tx_conv_word_ready = i2c_tx_word_ready_i & i2c_sel;

  tti_rx_word_to_byte u_rx_conv (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .word_valid_i (rx_conv_word_valid),
    .word_ready_o (rx_conv_word_ready),
    .word_data_i  (i2c_rx_word_data_i),
    .byte_valid_o (rx_conv_byte_valid),
    .byte_ready_i (rx_conv_byte_ready),
    .byte_data_o  (rx_conv_byte_data)
  );

  tti_tx_byte_to_word u_tx_conv (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .byte_valid_i (tx_conv_byte_valid),
    .byte_ready_o (tx_conv_byte_ready),
    .byte_data_i  (tx_queue_rdata_i),
    .word_valid_o (tx_conv_word_valid),
    .word_ready_i (tx_conv_word_ready),
    .word_data_o  (tx_conv_word_data)
  );

  always_comb begin
    // RX path
    rx_queue_wvalid_o   = i3c_sel ? i3c_rx_byte_valid_i : rx_conv_byte_valid;
    rx_queue_wdata_o    = i3c_sel ? i3c_rx_byte_data_i : rx_conv_byte_data;
    rx_queue_flush_o    = i3c_sel ? i3c_rx_flush_i : 1'b0;
    i3c_rx_byte_ready_o = i3c_sel ? rx_queue_wready_i : 1'b0;
    i2c_rx_word_ready_o = i2c_sel ? rx_conv_word_ready : 1'b0;

    // TX path
    tx_queue_rready_o   = i3c_sel ? i3c_tx_byte_ready_i : tx_conv_byte_ready;
    tx_queue_flush_o    = i3c_sel ? i3c_tx_flush_i : 1'b0;
    i3c_tx_byte_valid_o = i3c_sel ? tx_queue_rvalid_i : 1'b0;
    i3c_tx_byte_data_o  = tx_queue_rdata_i;
    i2c_tx_word_valid_o = i2c_sel ? tx_conv_word_valid : 1'b0;
    i2c_tx_word_data_o  = tx_conv_word_data;

    bus_event_o = i3c_sel ? i3c_bus_event_i : i2c_bus_event_i;
    bus_addr_o  = i3c_sel ? i3c_bus_addr_i : i2c_bus_addr_i;
  end

  // Sticky parity error, a finished status read clears it
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      err_o <= 1'b0;
    end else if (get_status_done_i) begin
      err_o <= 1'b0;
    end else if (parity_err_i) begin
      err_o <= 1'b1;
    end
  end

endmodule

`default_nettype wire

//--- source/tti_tx_byte_to_word.sv
// TX byte to word converter

`default_nettype none

`include "standby_defs.svh"

module tti_tx_byte_to_word (
  input  logic                   clk_i,
  input  logic                   rst_ni,

  input  logic                   byte_valid_i,
  output logic                   byte_ready_o,
  input  logic [`TTI_BYTE_W-1:0] byte_data_i,

  output logic                   word_valid_o,
  input  logic                   word_ready_i,
  output logic [`TTI_WORD_W-1:0] word_data_o
);

  localparam int unsigned last_idx = `TTI_BYTES_PER_WORD - 1;

  standby_pkg::tx_conv_state_e state_q;
  logic [`TTI_BYTE_IDX_W-1:0]  cnt_q;
  logic [`TTI_WORD_W-1:0]      word_q;

  logic byte_fire;
  logic word_fire;

  assign byte_ready_o = (state_q == standby_pkg::TX_COLLECT);
  assign word_valid_o = (state_q == standby_pkg::TX_HOLD);
  assign word_data_o  = word_q;

  assign byte_fire = byte_valid_i & byte_ready_o;
  assign word_fire = word_valid_o & word_ready_i;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= standby_pkg::TX_COLLECT;
      cnt_q   <= '0;
    end else begin
      if (byte_fire) begin
        // Counter wraps to zero on the fourth byte
        cnt_q <= cnt_q + 1'b1;
        if (cnt_q == last_idx[`TTI_BYTE_IDX_W-1:0]) begin
          state_q <= standby_pkg::TX_HOLD;
        end
      end else if (word_fire) begin
        state_q <= standby_pkg::TX_COLLECT;
      end
    end
  end

  // Shift in from the top so the first byte ends up in the LSB
  always_ff @(posedge clk_i) begin
    if (byte_fire) begin
      word_q <= {byte_data_i, word_q[`TTI_WORD_W-1:`TTI_BYTE_W]};
    end
  end

endmodule

`default_nettype wire

//--- source/tti_rx_word_to_byte.sv
// RX word to byte converter

`default_nettype none

`include "standby_defs.svh"

module tti_rx_word_to_byte (
  input  logic                   clk_i,
  input  logic                   rst_ni,

  input  logic                   word_valid_i,
  output logic                   word_ready_o,
  input  logic [`TTI_WORD_W-1:0] word_data_i,

  output logic                   byte_valid_o,
  input  logic                   byte_ready_i,
  output logic [`TTI_BYTE_W-1:0] byte_data_o
);

  localparam int unsigned last_idx = `TTI_BYTES_PER_WORD - 1;

  standby_pkg::rx_conv_state_e state_q;
  logic [`TTI_BYTE_IDX_W-1:0]  idx_q;
  logic [`TTI_WORD_W-1:0]      word_q;

  logic byte_fire;
  logic last_byte;
  logic word_fire;

  assign byte_valid_o = (state_q == standby_pkg::RX_SEND);
  assign byte_fire    = byte_valid_o & byte_ready_i;
  assign last_byte    = (idx_q == last_idx[`TTI_BYTE_IDX_W-1:0]);

  // Next word may enter as the last byte leaves
  assign word_ready_o = (state_q == standby_pkg::RX_IDLE) | (byte_fire & last_byte);
  assign word_fire    = word_valid_i & word_ready_o;

  // Bytes go out LSB first
  assign byte_data_o = word_q[idx_q*`TTI_BYTE_W +: `TTI_BYTE_W];

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= standby_pkg::RX_IDLE;
      idx_q   <= '0;
    end else begin
      if (word_fire) begin
        state_q <= standby_pkg::RX_SEND;
        idx_q   <= '0;
      end else if (byte_fire) begin
        if (last_byte) begin
          state_q <= standby_pkg::RX_IDLE;
          idx_q   <= '0;
        end else begin
          idx_q <= idx_q + 1'b1;
        end
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (word_fire) begin
      word_q <= word_data_i;
    end
  end

endmodule

`default_nettype wire

//--- source/standby_pkg.sv
// Standby TTI types

`default_nettype none

package standby_pkg;

  typedef enum logic {
    MODE_I2C = 1'b0,
    MODE_I3C = 1'b1
  } tti_mode_e;

  typedef enum logic {
    RX_IDLE = 1'b0,
    RX_SEND = 1'b1
  } rx_conv_state_e;

  typedef enum logic {
    TX_COLLECT = 1'b0,
    TX_HOLD    = 1'b1
  } tx_conv_state_e;

  typedef struct packed {
    logic i2c_active_en;
    logic i2c_standby_en;
    logic i3c_active_en;
    logic i3c_standby_en;
  } mode_cfg_t;

  typedef struct packed {
    logic start;
    logic rstart;
    logic stop;
  } bus_event_t;

  // Received address with RnW bit
  typedef struct packed {
    logic       valid;
    logic [6:0] addr;
    logic       rnw;
  } bus_addr_t;

endpackage

`default_nettype wire

//--- source/standby_defs.svh
// Standby TTI width definitions

`ifndef STANDBY_DEFS_SVH
`define STANDBY_DEFS_SVH

// Engine side word width
`define TTI_WORD_W 32

// Queue side byte width
`define TTI_BYTE_W 8

`define TTI_BYTES_PER_WORD 4
`define TTI_BYTE_IDX_W 2

`endif
